// ==== sources.f ====
hdl/cpu_pkg.sv
hdl/rename_decode.sv
hdl/free_list.sv
hdl/phys_regfile.sv
hdl/alu_execute.sv
hdl/result_commit.sv
hdl/rename_core.sv
test/rename_core_checker.sv
test/tb_rename_core.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_rename_core \
    && ./obj_dir/Vtb_rename_core > sim.log 2>&1 \
    || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// ==== test/tb_rename_core.sv ====
`timescale 1ns/1ps

module tb_rename_core;
    import cpu_pkg::*;

    localparam int MAX_CYCLES = 3000;  // about twice the longest run

    logic    clk;
    logic    rst;
    logic    i_instr_valid;
    instr_t  i_instr;
    logic    o_commit_valid;
    commit_t o_commit;

    word_t   ref_regs [NUM_AREGS];  // architectural state of the model
    commit_t exp_q [$];
    commit_t exp_c;
    string   cur_test = "reset";
    int      seed;
    int      cycle_count = 0;

    rename_core rename_core_inst (
        .clk(clk), .rst(rst),
        .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .o_commit_valid(o_commit_valid), .o_commit(o_commit)
    );

    bind rename_core rename_core_checker rename_core_checker_inst (
        .clk(clk), .rst(rst), .i_instr_valid(i_instr_valid),
        .i_commit_valid(o_commit_valid), .i_commit(o_commit)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reporting
    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            fail_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // instruction encoding and reference model
    function automatic instr_t rtype(input logic [5:0] fn, input int rs, input int rt,
                                     input int rd);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic instr_t itype(input logic [5:0] opc, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic commit_t predict(input instr_t ins);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [15:0] imm;
        areg_t       dst;
        word_t       a, b, res;
        logic        kept;
        opc  = ins[31:26];
        fn   = ins[5:0];
        imm  = ins[15:0];
        a    = ref_regs[ins[25:21]];
        b    = ref_regs[ins[20:16]];
        res  = '0;
        kept = 1'b1;
        if (opc == OP_RTYPE) begin
            dst = ins[15:11];
            case (fn)
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: kept = 1'b0;  // bubble
            endcase
        end else begin
            dst = ins[20:16];
            case (opc)
                OP_ADDIU: res = a + {{16{imm[15]}}, imm};
                OP_ANDI:  res = a & {16'h0000, imm};
                OP_ORI:   res = a | {16'h0000, imm};
                OP_LUI:   res = {imm, 16'h0000};
                default:  kept = 1'b0;
            endcase
        end
        if (kept && dst != '0) begin
            ref_regs[dst] = res;
        end
        return '{we: kept && (dst != '0), rd: dst, data: res};
    endfunction

    function automatic instr_t random_instr();
        int          sel, rs, rt, rd;
        logic [15:0] imm;
        sel = $unsigned($random(seed)) % 12;
        rs  = $unsigned($random(seed)) % 8;  // few registers, many dependencies
        rt  = $unsigned($random(seed)) % 8;
        rd  = $unsigned($random(seed)) % 8;
        imm = 16'($random(seed));
        case (sel)
            0:       return rtype(FN_ADDU, rs, rt, rd);
            1:       return rtype(FN_SUBU, rs, rt, rd);
            2:       return rtype(FN_AND, rs, rt, rd);
            3:       return rtype(FN_OR, rs, rt, rd);
            4:       return rtype(FN_XOR, rs, rt, rd);
            5:       return rtype(FN_SLT, rs, rt, rd);
            6:       return itype(OP_ADDIU, rs, rt, imm);
            7:       return itype(OP_ANDI, rs, rt, imm);
            8:       return itype(OP_ORI, rs, rt, imm);
            9:       return itype(OP_LUI, 0, rt, imm);
            10:      return itype(6'h23, rs, rt, imm);  // lw, not kept
            default: return rtype(6'h02, rs, rt, rd);   // srl, not kept
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    task automatic apply_reset();
        rst <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
    endtask

    task automatic issue(input instr_t ins);
        exp_q.push_back(predict(ins));
        @(posedge clk);
        i_instr_valid <= 1'b1;
        i_instr       <= ins;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            i_instr_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // commits are compared in order against the model
    always @(posedge clk) begin
        if (rst && o_commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("a commit appeared with no instruction outstanding in %s", cur_test);
                fail_run();
            end else begin
                exp_c = exp_q.pop_front();
                check_value("commit we", 32'(exp_c.we), 32'(o_commit.we));
                check_value("commit rd", 32'(exp_c.rd), 32'(o_commit.rd));
                check_value("commit data", exp_c.data, o_commit.data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_reset_idle();
        cur_test = "test_reset_idle";
        repeat (20) begin
            @(negedge clk);
            check_value("commit valid", 32'd0, 32'(o_commit_valid));
        end
    endtask

    task automatic test_each_op();
        cur_test = "test_each_op";
        issue(itype(OP_LUI, 0, 1, 16'h8000));
        issue(itype(OP_ORI, 1, 1, 16'h1234));    // r1 negative
        issue(itype(OP_LUI, 0, 2, 16'h0001));
        issue(itype(OP_ORI, 2, 2, 16'hf00f));    // r2 positive
        issue(rtype(FN_ADDU, 1, 2, 3));
        issue(rtype(FN_SUBU, 2, 1, 4));
        issue(rtype(FN_AND, 1, 2, 5));
        issue(rtype(FN_OR, 1, 2, 6));
        issue(rtype(FN_XOR, 1, 2, 7));
        issue(rtype(FN_SLT, 1, 2, 8));           // signed, gives 1
        issue(rtype(FN_SLT, 2, 1, 9));
        issue(itype(OP_ADDIU, 2, 10, 16'hfff0)); // minus 16
        issue(itype(OP_ADDIU, 0, 11, 16'h7fff));
        issue(itype(OP_ANDI, 1, 12, 16'hffff));
        issue(itype(OP_ORI, 0, 13, 16'h8001));
        issue(itype(OP_LUI, 0, 14, 16'hbeef));
        drain();
    endtask

    task automatic test_back_to_back();
        cur_test = "test_back_to_back";
        issue(itype(OP_ADDIU, 0, 15, 16'h0005));
        issue(rtype(FN_ADDU, 15, 15, 15));       // chain through the bypass
        issue(rtype(FN_ADDU, 15, 15, 15));
        issue(rtype(FN_SUBU, 15, 0, 16));
        issue(itype(OP_ORI, 0, 17, 16'h00ff));
        issue(itype(OP_LUI, 0, 18, 16'h1111));
        issue(rtype(FN_XOR, 17, 16, 19));        // distance 2 and 3
        issue(rtype(FN_OR, 18, 19, 20));
        issue(rtype(FN_SLT, 20, 15, 21));
        drain();
    endtask

    task automatic test_zero_and_nop();
        cur_test = "test_zero_and_nop";
        issue(itype(OP_ORI, 0, 0, 16'h1234));
        issue(rtype(FN_ADDU, 1, 2, 0));
        issue(itype(6'h23, 1, 2, 16'h0004));     // lw
        issue(itype(6'h04, 1, 2, 16'h0010));     // beq
        issue(rtype(6'h08, 31, 0, 0));           // jr
        issue(rtype(6'h00, 0, 1, 5));            // sll must leave r5 alone
        issue(rtype(FN_ADDU, 0, 0, 22));
        issue(rtype(FN_OR, 0, 5, 23));
        drain();
    endtask

    task automatic test_random_stream();
        int k;
        cur_test = "test_random_stream";
        seed     = 32'h67a6_94af;
        for (int n = 0; n < 300; n++) begin
            issue(random_instr());
            k = $unsigned($random(seed)) % 4;
            idle(k);
        end
        drain();
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        for (int i = 0; i < NUM_AREGS; i++) begin
            ref_regs[i] = '0;
        end
        apply_reset();
        test_reset_idle();
        test_each_op();
        test_back_to_back();
        test_zero_and_nop();
        test_random_stream();
        if (exp_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("%0d expected commits never appeared", exp_q.size());
            fail_run();
        end
    end

endmodule

// ==== test/rename_core_checker.sv ====
`timescale 1ns/1ps

module rename_core_checker (
    input logic             clk,
    input logic             rst,
    input logic             i_instr_valid,
    input logic             i_commit_valid,
    input cpu_pkg::commit_t i_commit
);

    //////////////////////////////////////////////////////////////////////
    // three stage pipe, fixed latency
    a_latency: assert property (@(posedge clk) disable iff (!rst)
        i_commit_valid == $past(i_instr_valid, 3))
        else $error("commit strobe does not follow the input strobe by 3 cycles");

    a_zero_dst: assert property (@(posedge clk) disable iff (!rst)
        (i_commit_valid && i_commit.rd == '0) |-> !i_commit.we)
        else $error("commit to register 0 has its write enable set");

    a_known_data: assert property (@(posedge clk) disable iff (!rst)
        i_commit_valid |-> !$isunknown(i_commit.data))  // x on data
        else $error("commit data holds unknown bits");

endmodule

// ==== hdl/rename_core.sv ====
`timescale 1ns/1ps

module rename_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_instr_valid,
    input  cpu_pkg::instr_t  i_instr,
    output logic             o_commit_valid,
    output cpu_pkg::commit_t o_commit
);
    import cpu_pkg::*;

    logic       alloc, release_en, uop_valid, ex_valid, wr_en;
    preg_t      free_preg, release_preg, raddr0, raddr1, wr_preg;
    word_t      rdata0, rdata1, wr_data;
    uop_t       uop;
    ex_result_t ex;

    //////////////////////////////////////////////////////////////////////
    // decode and rename
    rename_decode rename_decode_inst (
        .clk(clk), .rst(rst),
        .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .i_free_preg(free_preg), .o_alloc(alloc),
        .o_uop_valid(uop_valid), .o_uop(uop)
    );

    free_list free_list_inst (
        .clk(clk), .rst(rst),
        .i_alloc(alloc), .i_release(release_en),
        .i_release_preg(release_preg), .o_free_preg(free_preg)
    );

    //////////////////////////////////////////////////////////////////////
    // execute, register file, writeback
    phys_regfile phys_regfile_inst (
        .clk(clk), .rst(rst),
        .i_raddr0(raddr0), .i_raddr1(raddr1),
        .i_wr_en(wr_en), .i_wr_preg(wr_preg), .i_wr_data(wr_data),
        .o_rdata0(rdata0), .o_rdata1(rdata1)
    );

    alu_execute alu_execute_inst (
        .clk(clk), .rst(rst),
        .i_uop_valid(uop_valid), .i_uop(uop),
        .i_rdata0(rdata0), .i_rdata1(rdata1),
        .o_raddr0(raddr0), .o_raddr1(raddr1),
        .o_ex_valid(ex_valid), .o_ex(ex)
    );

    result_commit result_commit_inst (
        .clk(clk), .rst(rst),
        .i_ex_valid(ex_valid), .i_ex(ex),
        .o_wr_en(wr_en), .o_wr_preg(wr_preg), .o_wr_data(wr_data),
        .o_release(release_en), .o_release_preg(release_preg),
        .o_commit_valid(o_commit_valid), .o_commit(o_commit)
    );

endmodule

// ==== hdl/result_commit.sv ====
`timescale 1ns/1ps

module result_commit (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ex_valid,
    input  cpu_pkg::ex_result_t i_ex,
    output logic                o_wr_en,
    output cpu_pkg::preg_t      o_wr_preg,
    output cpu_pkg::word_t      o_wr_data,
    output logic                o_release,
    output cpu_pkg::preg_t      o_release_preg,
    output logic                o_commit_valid,
    output cpu_pkg::commit_t    o_commit
);
    import cpu_pkg::*;

    // writeback lands on the same edge as the commit register
    assign o_wr_en   = i_ex_valid && i_ex.we;
    assign o_wr_preg = i_ex.p_rd;
    assign o_wr_data = i_ex.data;

    // in order, no squash, so the old mapping is dead right away
    assign o_release      = o_wr_en;
    assign o_release_preg = i_ex.p_old;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_commit_valid <= 1'b0;
        end else begin
            o_commit_valid <= i_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ex_valid) begin
            o_commit <= '{we: i_ex.we, rd: i_ex.rd, data: i_ex.data};
        end
    end

endmodule

// ==== hdl/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_uop_valid,
    input  cpu_pkg::uop_t       i_uop,
    input  cpu_pkg::word_t      i_rdata0,
    input  cpu_pkg::word_t      i_rdata1,
    output cpu_pkg::preg_t      o_raddr0,
    output cpu_pkg::preg_t      o_raddr1,
    output logic                o_ex_valid,
    output cpu_pkg::ex_result_t o_ex
);
    import cpu_pkg::*;

    logic       byp_a, byp_b;
    word_t      op_a, op_b, rt_val;
    word_t      alu_out;
    ex_result_t ex_d;

    assign o_raddr0 = i_uop.p_rs;
    assign o_raddr1 = i_uop.p_rt;

    //////////////////////////////////////////////////////////////////////
    // operand select
    // previous result is still in flight to the register file
    assign byp_a  = o_ex_valid && o_ex.we && (o_ex.p_rd == i_uop.p_rs);
    assign byp_b  = o_ex_valid && o_ex.we && (o_ex.p_rd == i_uop.p_rt);
    assign op_a   = byp_a ? o_ex.data : i_rdata0;
    assign rt_val = byp_b ? o_ex.data : i_rdata1;
    assign op_b   = i_uop.use_imm ? i_uop.imm : rt_val;

    always_comb begin
        case (i_uop.alu_op)
            ALU_ADDU, ALU_ADDIU: alu_out = op_a + op_b;
            ALU_SUBU:            alu_out = op_a - op_b;
            ALU_AND, ALU_ANDI:   alu_out = op_a & op_b;
            ALU_OR, ALU_ORI:     alu_out = op_a | op_b;
            ALU_XOR:             alu_out = op_a ^ op_b;
            ALU_SLT:             alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_LUI:             alu_out = op_b;  // imm already shifted
            default:             alu_out = '0;
        endcase
    end

    always_comb begin
        ex_d.we    = i_uop.we;  // decode clears it for a bubble
        ex_d.rd    = i_uop.rd;
        ex_d.p_rd  = i_uop.p_rd;
        ex_d.p_old = i_uop.p_old;
        ex_d.data  = alu_out;
    end

    //////////////////////////////////////////////////////////////////////
    // execute to result register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_ex_valid <= 1'b0;
        end else begin
            o_ex_valid <= i_uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_uop_valid) begin
            o_ex <= ex_d;
        end
    end

endmodule

// ==== hdl/phys_regfile.sv ====
`timescale 1ns/1ps

module phys_regfile (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::preg_t i_raddr0,
    input  cpu_pkg::preg_t i_raddr1,
    input  logic           i_wr_en,
    input  cpu_pkg::preg_t i_wr_preg,
    input  cpu_pkg::word_t i_wr_data,
    output cpu_pkg::word_t o_rdata0,
    output cpu_pkg::word_t o_rdata1
);
    import cpu_pkg::*;

    word_t regs [NUM_PREGS];

    // async read, no write-through
    assign o_rdata0 = regs[i_raddr0];
    assign o_rdata1 = regs[i_raddr1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_preg] <= i_wr_data;
        end
    end

endmodule

// ==== hdl/free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_alloc,
    input  logic           i_release,
    input  cpu_pkg::preg_t i_release_preg,
    output cpu_pkg::preg_t o_free_preg
);
    import cpu_pkg::*;

    localparam int FL_DEPTH = NUM_PREGS - NUM_AREGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);

    preg_t            fl_mem [FL_DEPTH];
    logic [PTR_W-1:0] head;  // next register handed out
    logic [PTR_W-1:0] tail;  // next slot for a released one

    // head value is offered every cycle, the pop happens on the edge
    assign o_free_preg = fl_mem[head];

    //////////////////////////////////////////////////////////////////////
    // circular queue, pointers wrap on their own
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= preg_t'(NUM_AREGS + i);
            end
            head <= '0;
            tail <= '0;  // full, tail sits on head
        end else begin
            if (i_alloc) begin
                head <= head + 1'b1;
            end
            // a release always follows an earlier alloc, so no overrun
            if (i_release) begin
                fl_mem[tail] <= i_release_preg;
                tail         <= tail + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/rename_decode.sv ====
`timescale 1ns/1ps

module rename_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_instr_valid,
    input  cpu_pkg::instr_t  i_instr,
    input  cpu_pkg::preg_t   i_free_preg,
    output logic             o_alloc,
    output logic             o_uop_valid,
    output cpu_pkg::uop_t    o_uop
);
    import cpu_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    areg_t       l_rs, l_rt, l_rd, l_dst;
    logic        is_rtype;
    logic        dec_we;
    alu_op_e     op;
    word_t       imm_ext;
    uop_t        uop_d;

    preg_t map_table [NUM_AREGS];  // logical to physical

    assign opcode   = i_instr[OPC_LSB +: 6];
    assign funct    = i_instr[FN_LSB +: 6];
    assign imm16    = i_instr[IMM_LSB +: 16];
    assign l_rs     = i_instr[RS_LSB +: 5];
    assign l_rt     = i_instr[RT_LSB +: 5];
    assign l_rd     = i_instr[RD_LSB +: 5];
    assign is_rtype = (opcode == OP_RTYPE);
    assign l_dst    = is_rtype ? l_rd : l_rt;

    //////////////////////////////////////////////////////////////////////
    // opcode decode, anything unknown becomes a bubble
    always_comb begin
        op = ALU_NOP;
        if (is_rtype) begin
            case (funct)
                FN_ADDU: op = ALU_ADDU;
                FN_SUBU: op = ALU_SUBU;
                FN_AND:  op = ALU_AND;
                FN_OR:   op = ALU_OR;
                FN_XOR:  op = ALU_XOR;
                FN_SLT:  op = ALU_SLT;
                default: op = ALU_NOP;
            endcase
        end else begin
            case (opcode)
                OP_ADDIU: op = ALU_ADDIU;
                OP_ANDI:  op = ALU_ANDI;
                OP_ORI:   op = ALU_ORI;
                OP_LUI:   op = ALU_LUI;
                default:  op = ALU_NOP;
            endcase
        end
    end

    always_comb begin
        case (op)
            ALU_ADDIU: imm_ext = {{16{imm16[15]}}, imm16};
            ALU_LUI:   imm_ext = {imm16, 16'h0000};
            default:   imm_ext = {16'h0000, imm16};  // andi, ori
        endcase
    end

    assign dec_we  = (op != ALU_NOP) && (l_dst != '0);
    assign o_alloc = i_instr_valid && dec_we;  // free list head taken this cycle

    always_comb begin
        uop_d.alu_op  = op;
        uop_d.p_rs    = map_table[l_rs];
        uop_d.p_rt    = map_table[l_rt];
        uop_d.use_imm = !is_rtype;
        uop_d.imm     = imm_ext;
        uop_d.we      = dec_we;
        uop_d.rd      = l_dst;
        uop_d.p_rd    = i_free_preg;
        uop_d.p_old   = map_table[l_dst];
    end

    //////////////////////////////////////////////////////////////////////
    // map table, identity after reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_table[i] <= preg_t'(i);
            end
        end else if (o_alloc) begin
            map_table[l_dst] <= i_free_preg;
        end
    end

    // decode to execute register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_uop_valid <= 1'b0;
        end else begin
            o_uop_valid <= i_instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            o_uop <= uop_d;
        end
    end

endmodule

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and counts
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  preg_t;

    localparam int NUM_AREGS = 32;
    localparam int NUM_PREGS = 64;

    // instruction field positions
    localparam int OPC_LSB = 26;  // 6 bit opcode
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int FN_LSB  = 0;   // 6 bit funct
    localparam int IMM_LSB = 0;   // 16 bit immediate

    //////////////////////////////////////////////////////////////////////
    // opcode and funct encodings, mips style
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_ADDIU,
        ALU_ANDI,
        ALU_ORI,
        ALU_LUI
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // stage payloads
    typedef struct packed {
        alu_op_e alu_op;
        preg_t   p_rs;
        preg_t   p_rt;
        logic    use_imm;
        word_t   imm;     // already extended
        logic    we;
        areg_t   rd;      // logical destination
        preg_t   p_rd;    // newly allocated
        preg_t   p_old;   // freed when this one writes back
    } uop_t;

    typedef struct packed {
        logic  we;
        areg_t rd;
        preg_t p_rd;
        preg_t p_old;
        word_t data;
    } ex_result_t;

    typedef struct packed {
        logic  we;
        areg_t rd;
        word_t data;
    } commit_t;

endpackage
